// File: include/regRename_cfg.svh
`ifndef REGRENAME_CFG_SVH
`define REGRENAME_CFG_SVH

// source operand read ports on the alias table
`define RR_READ_PORTS 2

// width of a rename tag
`define RR_TAG_BITS 6

// reorder buffer entries, a power of two below half the tag space
`define RR_ROB_DEPTH 16

// index into the reorder buffer, log2 of the depth
`define RR_ROB_IDX_BITS 4

`endif

// File: verilog/renamePkg.sv
`include "regRename_cfg.svh"

package renamePkg;

    // one architectural register in the alias table
    // avail set means value is the committed result
    // avail clear means tag names the pending writer
    typedef struct packed {
        logic                    avail;
        logic [`RR_TAG_BITS-1:0] tag;
        logic [31:0]             value;
    } ratEntry;

    // tag view of an operand word with the tag in the low bits
    typedef struct packed {
        logic [31-`RR_TAG_BITS:0] pad;
        logic [`RR_TAG_BITS-1:0]  tag;
    } operandTag;

    // operand handed to issue
    // the ready bit next to it selects which view is meaningful
    typedef union packed {
        logic [31:0] value;
        operandTag   pend;
    } operandWord;

endpackage

// File: verilog/registerAliasTable.sv
`timescale 1ns/100ps
`include "regRename_cfg.svh"

module registerAliasTable (
    input  logic                    clk,
    input  logic                    rst,
    // rename request, already qualified by the reorder buffer
    input  logic                    issueEn,
    input  logic [4:0]              issueDest,
    input  logic [4:0]              issueSrc [`RR_READ_PORTS],
    // in-order commit from the reorder buffer head
    input  logic                    commitValid,
    input  logic [4:0]              commitReg,
    input  logic [`RR_TAG_BITS-1:0] commitTag,
    input  logic [31:0]             commitResult,
    // flush strobe for everything younger than branchTag
    input  logic                    branchTaken,
    input  logic [`RR_TAG_BITS-1:0] branchTag,
    // tag given to the instruction presented this cycle
    output logic [`RR_TAG_BITS-1:0] issueTag,
    // raw entry fields per source port
    output logic                    srcAvail [`RR_READ_PORTS],
    output logic [`RR_TAG_BITS-1:0] srcTag [`RR_READ_PORTS],
    output logic [31:0]             srcValue [`RR_READ_PORTS]
);

    // rename map, one record per architectural register
    renamePkg::ratEntry ratMem [32];

    // next tag to hand out
    logic [`RR_TAG_BITS-1:0] tagCnt;

    // distance of each pending tag from the branch
    logic [`RR_TAG_BITS-1:0] tagDelta [32];
    // pending writer is younger than the branch
    logic flushHit [32];

    // commit qualifiers
    logic commitWr;
    logic commitClear;

    assign issueTag = tagCnt;

    // register zero is hardwired, so commits to it are dropped
    assign commitWr = commitValid && (commitReg != 5'd0);

    // only the writer the map still points at may release the register
    // an older writer of a renamed register leaves it pending
    assign commitClear = commitWr && (ratMem[commitReg].tag == commitTag);

    // combinational source lookup
    always_comb begin
        for (int p = 0; p < `RR_READ_PORTS; p++) begin
            srcAvail[p] = ratMem[issueSrc[p]].avail;
            srcTag[p]   = ratMem[issueSrc[p]].tag;
            srcValue[p] = ratMem[issueSrc[p]].value;
        end
    end

    // age test by signed tag difference
    // positive means the register's writer came after the branch
    always_comb begin
        for (int r = 0; r < 32; r++) begin
            tagDelta[r] = ratMem[r].tag - branchTag;
            flushHit[r] = !ratMem[r].avail && ($signed(tagDelta[r]) > 0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tagCnt <= '0;
            // all registers start committed with value zero
            for (int r = 0; r < 32; r++) begin
                ratMem[r].avail <= 1'b1;
                ratMem[r].value <= '0;
            end
        end else if (branchTaken) begin
            // restart numbering right after the branch
            tagCnt <= branchTag + 1'b1;
            // flushed writers fall back to the last committed value
            for (int r = 0; r < 32; r++) begin
                if (flushHit[r]) begin
                    ratMem[r].avail <= 1'b1;
                end
            end
        end else begin
            if (commitWr) begin
                ratMem[commitReg].value <= commitResult;
                if (commitClear) begin
                    ratMem[commitReg].avail <= 1'b1;
                end
            end
            // issue comes second so a same-edge rename of the
            // committing register keeps it pending on the new tag
            if (issueEn) begin
                tagCnt <= tagCnt + 1'b1;
                if (issueDest != 5'd0) begin
                    ratMem[issueDest].avail <= 1'b0;
                    ratMem[issueDest].tag   <= tagCnt;
                end
            end
        end
    end

    // issue and flush arrive from outside and the reorder buffer
    // neither may be seen while the core is held in reset
    assert property (@(posedge clk) rst |-> (!issueEn && !branchTaken))
        else $error("issue or flush strobe seen during reset");

endmodule

// File: verilog/reorderBuffer.sv
`timescale 1ns/100ps
`include "regRename_cfg.svh"

module reorderBuffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issueValid,
    input  logic [4:0]              issueDest,
    // write slot comes from the alias table tag counter
    input  logic [`RR_TAG_BITS-1:0] issueTag,
    input  logic                    exValid,
    input  logic [`RR_TAG_BITS-1:0] exTag,
    input  logic [31:0]             exResult,
    input  logic                    branchTaken,
    input  logic [`RR_TAG_BITS-1:0] branchTag,
    output logic                    issueAccept,
    output logic                    commitValid,
    output logic [4:0]              commitReg,
    output logic [`RR_TAG_BITS-1:0] commitTag,
    output logic [31:0]             commitResult
);

    localparam int Depth   = `RR_ROB_DEPTH;
    localparam int IdxBits = `RR_ROB_IDX_BITS;
    localparam int TagBits = `RR_TAG_BITS;
    localparam int CntBits = IdxBits + 1;

    // per entry control and payload
    logic               robValid  [Depth];
    logic               robDone   [Depth];
    logic [4:0]         robDest   [Depth];
    logic [31:0]        robResult [Depth];

    // oldest live tag and number of live entries
    logic [TagBits-1:0] headTag;
    logic [CntBits-1:0] count;

    logic [IdxBits-1:0] headIdx;
    logic [IdxBits-1:0] issueIdx;
    logic [IdxBits-1:0] exIdx;
    logic               full;

    // result window check
    logic [TagBits-1:0] exOff;
    logic               exInFlight;
    logic               exTake;

    // state after a flush
    logic [TagBits-1:0] brOff;
    logic [CntBits-1:0] brCount;
    logic [TagBits-1:0] brHead;
    logic [IdxBits-1:0] slotOff [Depth];
    logic               keep    [Depth];

    assign headIdx  = headTag[IdxBits-1:0];
    assign issueIdx = issueTag[IdxBits-1:0];
    assign exIdx    = exTag[IdxBits-1:0];
    assign full     = (count == CntBits'(Depth));

    // no issue while full or while a flush is under way
    assign issueAccept = issueValid && !full && !branchTaken;

    // head retires once its result is in
    assign commitValid  = robValid[headIdx] && robDone[headIdx];
    assign commitReg    = robDest[headIdx];
    assign commitTag    = headTag;
    assign commitResult = robResult[headIdx];

    // results for tags outside the live window were flushed
    assign exOff      = exTag - headTag;
    assign exInFlight = exOff < TagBits'(count);
    assign exTake     = exValid && exInFlight;

    always_comb begin
        brOff = branchTag - headTag;
        if ($signed(brOff) < 0) begin
            // branch already retired so the window empties
            brCount = '0;
            brHead  = branchTag + 1'b1;
        end else begin
            // keep head up to and including the branch
            brCount = brOff[CntBits-1:0] + 1'b1;
            brHead  = headTag;
        end
        for (int i = 0; i < Depth; i++) begin
            slotOff[i] = IdxBits'(i) - headIdx;
            keep[i]    = {1'b0, slotOff[i]} < brCount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headTag <= '0;
            count   <= '0;
            for (int i = 0; i < Depth; i++) begin
                robValid[i] <= 1'b0;
                robDone[i]  <= 1'b0;
            end
        end else begin
            if (exTake) begin
                robDone[exIdx] <= 1'b1;
            end
            if (branchTaken) begin
                // commit waits one edge behind the flush
                headTag <= brHead;
                count   <= brCount;
                for (int i = 0; i < Depth; i++) begin
                    if (!keep[i]) begin
                        robValid[i] <= 1'b0;
                    end
                end
            end else begin
                if (commitValid) begin
                    robValid[headIdx] <= 1'b0;
                    headTag           <= headTag + 1'b1;
                end
                if (issueAccept) begin
                    robValid[issueIdx] <= 1'b1;
                    robDone[issueIdx]  <= 1'b0;
                end
                count <= count + CntBits'(issueAccept) - CntBits'(commitValid);
            end
        end
    end

    // payload written alongside the control bits
    always_ff @(posedge clk) begin
        if (issueAccept) begin
            robDest[issueIdx] <= issueDest;
        end
        if (exTake) begin
            robResult[exIdx] <= exResult;
        end
    end

    // tail slot from the alias table is free on every accepted issue
    // a full buffer would show it still occupied
    assert property (@(posedge clk) disable iff (rst) issueAccept |-> !robValid[issueIdx])
        else $error("issue accepted into an occupied slot");

    // live window and entry valid bits stay in step
    assert property (@(posedge clk) disable iff (rst)
        (exValid && exInFlight) |-> robValid[exIdx])
        else $error("result names a free reorder buffer entry");

endmodule

// File: verilog/operandSelect.sv
`timescale 1ns/100ps
`include "regRename_cfg.svh"

module operandSelect (
    input  logic [4:0]              srcReg [`RR_READ_PORTS],
    input  logic                    srcAvail [`RR_READ_PORTS],
    input  logic [`RR_TAG_BITS-1:0] srcTag [`RR_READ_PORTS],
    input  logic [31:0]             srcValue [`RR_READ_PORTS],
    // commit under way this cycle
    input  logic                    commitValid,
    input  logic [4:0]              commitReg,
    input  logic [`RR_TAG_BITS-1:0] commitTag,
    input  logic [31:0]             commitResult,
    output renamePkg::operandWord   opWord [`RR_READ_PORTS],
    output logic                    opReady [`RR_READ_PORTS]
);

    // pending source whose writer is retiring right now
    logic fwdHit [`RR_READ_PORTS];

    always_comb begin
        for (int p = 0; p < `RR_READ_PORTS; p++) begin
            fwdHit[p] = !srcAvail[p] && commitValid &&
                        (commitReg == srcReg[p]) && (commitTag == srcTag[p]);

            if (srcReg[p] == 5'd0) begin
                // register zero is constant
                opReady[p]      = 1'b1;
                opWord[p].value = '0;
            end else if (fwdHit[p]) begin
                // bypass the table write that lands next edge
                opReady[p]      = 1'b1;
                opWord[p].value = commitResult;
            end else if (srcAvail[p]) begin
                opReady[p]      = 1'b1;
                opWord[p].value = srcValue[p];
            end else begin
                // hand the tag to issue so it can wake up later
                opReady[p]         = 1'b0;
                opWord[p].pend.pad = '0;
                opWord[p].pend.tag = srcTag[p];
            end
        end
    end

endmodule

// File: verilog/renameStage.sv
`timescale 1ns/100ps
`include "regRename_cfg.svh"

module renameStage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issueValid,
    input  logic [4:0]              issueDest,
    input  logic [4:0]              issueSrc [`RR_READ_PORTS],
    input  logic                    exValid,
    input  logic [`RR_TAG_BITS-1:0] exTag,
    input  logic [31:0]             exResult,
    input  logic                    branchTaken,
    input  logic [`RR_TAG_BITS-1:0] branchTag,
    output logic                    issueAccept,
    output logic [`RR_TAG_BITS-1:0] issueTag,
    output renamePkg::operandWord   opWord [`RR_READ_PORTS],
    output logic                    opReady [`RR_READ_PORTS],
    output logic                    commitValid,
    output logic [4:0]              commitReg,
    output logic [`RR_TAG_BITS-1:0] commitTag,
    output logic [31:0]             commitResult
);

    // raw table entries for each source
    logic                    srcAvail [`RR_READ_PORTS];
    logic [`RR_TAG_BITS-1:0] srcTag [`RR_READ_PORTS];
    logic [31:0]             srcValue [`RR_READ_PORTS];

    registerAliasTable i_rat (
        .clk          (clk),
        .rst          (rst),
        .issueEn      (issueAccept),
        .issueDest    (issueDest),
        .issueSrc     (issueSrc),
        .commitValid  (commitValid),
        .commitReg    (commitReg),
        .commitTag    (commitTag),
        .commitResult (commitResult),
        .branchTaken  (branchTaken),
        .branchTag    (branchTag),
        .issueTag     (issueTag),
        .srcAvail     (srcAvail),
        .srcTag       (srcTag),
        .srcValue     (srcValue)
    );

    reorderBuffer i_rob (
        .clk          (clk),
        .rst          (rst),
        .issueValid   (issueValid),
        .issueDest    (issueDest),
        .issueTag     (issueTag),
        .exValid      (exValid),
        .exTag        (exTag),
        .exResult     (exResult),
        .branchTaken  (branchTaken),
        .branchTag    (branchTag),
        .issueAccept  (issueAccept),
        .commitValid  (commitValid),
        .commitReg    (commitReg),
        .commitTag    (commitTag),
        .commitResult (commitResult)
    );

    operandSelect i_opSel (
        .srcReg       (issueSrc),
        .srcAvail     (srcAvail),
        .srcTag       (srcTag),
        .srcValue     (srcValue),
        .commitValid  (commitValid),
        .commitReg    (commitReg),
        .commitTag    (commitTag),
        .commitResult (commitResult),
        .opWord       (opWord),
        .opReady      (opReady)
    );

endmodule

// File: verification/renameStageTb.sv
`timescale 1ns/100ps
`include "regRename_cfg.svh"

module renameStageTb;

    typedef enum logic [2:0] {OpIdle, OpIssue, OpResult, OpBranch, OpWait} opKind;

    // one table row is one cycle, except a wait row which repeats
    typedef struct {
        opKind                   op;
        int                      test;
        logic [4:0]              dest;
        logic [4:0]              src0;
        logic [4:0]              src1;
        logic [`RR_TAG_BITS-1:0] tag;
        logic                    rdy0;
        logic                    rdy1;
    } stimRow;

    localparam int WaitLimit = 20;

    logic                    clk;
    logic                    rst;
    logic                    issueValid;
    logic [4:0]              issueDest;
    logic [4:0]              issueSrc [`RR_READ_PORTS];
    logic                    exValid;
    logic [`RR_TAG_BITS-1:0] exTag;
    logic [31:0]             exResult;
    logic                    branchTaken;
    logic [`RR_TAG_BITS-1:0] branchTag;
    logic                    issueAccept;
    logic [`RR_TAG_BITS-1:0] issueTag;
    renamePkg::operandWord   opWord [`RR_READ_PORTS];
    logic                    opReady [`RR_READ_PORTS];
    logic                    commitValid;
    logic [4:0]              commitReg;
    logic [`RR_TAG_BITS-1:0] commitTag;
    logic [31:0]             commitResult;

    // reference model, queue entries indexed by the full tag
    logic [31:0]             mValue [32];
    logic                    mPend  [32];
    logic [`RR_TAG_BITS-1:0] mTag   [32];
    logic                    qValid [64];
    logic                    qDone  [64];
    logic [4:0]              qDest  [64];
    logic [31:0]             qRes   [64];
    logic [`RR_TAG_BITS-1:0] mHead;
    logic [`RR_TAG_BITS-1:0] mNext;
    logic                    mCom;
    logic                    mAcc;

    stimRow      rows [$];
    logic [15:0] lfsrState;
    logic [31:0] curResult;
    int          errCount;
    int          checkCount;
    int          testErr;
    int          testCnt;
    int          curTest;

    renameStage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one step per result bit
    task automatic randWord(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsrState = lfsrNext(lfsrState);
            w[b] = lfsrState[0];
        end
    endtask

    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            $display("[ERROR] %s expected %h actual %h at %0t", name, expVal, actVal, $time);
            errCount++;
            testErr++;
        end
    endtask

    task automatic addRow(input opKind op, input int test, input int dest, input int s0,
                          input int s1, input int tag, input int r0, input int r1);
        stimRow r;
        r.op   = op;
        r.test = test;
        r.dest = 5'(dest);
        r.src0 = 5'(s0);
        r.src1 = 5'(s1);
        r.tag  = `RR_TAG_BITS'(tag);
        r.rdy0 = 1'(r0);
        r.rdy1 = 1'(r1);
        rows.push_back(r);
    endtask

    task automatic driveRow(input stimRow r);
        issueValid  = (r.op == OpIssue);
        issueDest   = r.dest;
        issueSrc[0] = r.src0;
        issueSrc[1] = r.src1;
        exValid     = (r.op == OpResult);
        exTag       = r.tag;
        branchTaken = (r.op == OpBranch);
        branchTag   = r.tag;
        curResult   = '0;
        if (r.op == OpResult) begin
            randWord(curResult);
        end
        exResult = curResult;
    endtask

    // operand as the rules give it, with same-cycle commit bypass
    function automatic logic [31:0] expectOperand(input logic [4:0] r);
        if (r == 5'd0) begin
            return '0;
        end else if (mPend[r] && mCom && qDest[mHead] == r && mTag[r] == mHead) begin
            return qRes[mHead];
        end else if (!mPend[r]) begin
            return mValue[r];
        end
        return 32'(mTag[r]);
    endfunction

    task automatic checkOutputs(input stimRow r);
        logic [4:0]  src;
        logic        rdy;
        logic [31:0] word;
        mCom = qValid[mHead] && qDone[mHead];
        mAcc = issueValid && !branchTaken && ((mNext - mHead) != `RR_TAG_BITS'(`RR_ROB_DEPTH));
        checkVal("issueAccept", 32'(mAcc), 32'(issueAccept));
        checkVal("issueTag", 32'(mNext), 32'(issueTag));
        checkVal("commitValid", 32'(mCom), 32'(commitValid));
        if (mCom) begin
            checkVal("commitReg", 32'(qDest[mHead]), 32'(commitReg));
            checkVal("commitTag", 32'(mHead), 32'(commitTag));
            checkVal("commitResult", qRes[mHead], commitResult);
        end
        for (int p = 0; p < `RR_READ_PORTS; p++) begin
            src  = (p == 0) ? r.src0 : r.src1;
            rdy  = (p == 0) ? r.rdy0 : r.rdy1;
            word = expectOperand(src);
            checkVal($sformatf("opReady[%0d]", p), 32'(rdy), 32'(opReady[p]));
            if (rdy) begin
                checkVal($sformatf("opWord[%0d].value", p), word, opWord[p].value);
            end else begin
                checkVal($sformatf("opWord[%0d].tag", p), word, 32'(opWord[p].pend.tag));
            end
        end
    endtask

    // advance the model across the coming edge
    task automatic updateModel(input stimRow r);
        logic [`RR_TAG_BITS-1:0] cnt;
        logic [`RR_TAG_BITS-1:0] diff;
        logic [4:0]              d;
        cnt  = mNext - mHead;
        diff = r.tag - mHead;
        // late results for flushed tags fall outside the window
        if (r.op == OpResult && diff < cnt) begin
            qDone[r.tag] = 1'b1;
            qRes[r.tag]  = curResult;
        end
        if (r.op == OpBranch) begin
            for (int t = 0; t < 64; t++) begin
                diff = `RR_TAG_BITS'(t) - r.tag;
                if ($signed(diff) > 0) begin
                    qValid[t] = 1'b0;
                end
            end
            // younger writers fall back to the committed value
            for (int g = 0; g < 32; g++) begin
                diff = mTag[g] - r.tag;
                if (mPend[g] && $signed(diff) > 0) begin
                    mPend[g] = 1'b0;
                end
            end
            diff = r.tag - mHead;
            if ($signed(diff) < 0) begin
                mHead = r.tag + 1'b1;
            end
            mNext = r.tag + 1'b1;
        end else begin
            if (mCom) begin
                d = qDest[mHead];
                if (d != 5'd0) begin
                    mValue[d] = qRes[mHead];
                    if (mPend[d] && mTag[d] == mHead) begin
                        mPend[d] = 1'b0;
                    end
                end
                qValid[mHead] = 1'b0;
                mHead = mHead + 1'b1;
            end
            if (mAcc) begin
                qValid[mNext] = 1'b1;
                qDone[mNext]  = 1'b0;
                qDest[mNext]  = r.dest;
                if (r.dest != 5'd0) begin
                    mPend[r.dest] = 1'b1;
                    mTag[r.dest]  = mNext;
                end
                mNext = mNext + 1'b1;
            end
        end
    endtask

    // a wait row idles until commitValid shows up
    task automatic applyRow(input stimRow r);
        int  waitCnt;
        bit  done;
        waitCnt = 0;
        done    = 1'b0;
        while (!done) begin
            @(posedge clk);
            #2;
            driveRow(r);
            #8;
            if (r.op != OpWait || commitValid) begin
                checkOutputs(r);
                done = 1'b1;
            end else if (waitCnt >= WaitLimit) begin
                $display("timeout: commitValid never rose in test %0d", r.test);
                errCount++;
                testErr++;
                done = 1'b1;
            end else begin
                mCom = qValid[mHead] && qDone[mHead];
                mAcc = 1'b0;
                checkVal("commitValid", 32'(mCom), 32'(commitValid));
                waitCnt++;
            end
            updateModel(r);
        end
    endtask

    task automatic reportTest();
        testCnt++;
        if (testErr == 0) begin
            $display("test %0d: ok", curTest);
        end else begin
            $display("test %0d: %0d errors", curTest, testErr);
        end
    endtask

    task automatic buildTable();
        // test 1 reset state and first tags
        addRow(OpIdle,   1, 0, 0, 5, 0, 1, 1);
        addRow(OpIssue,  1, 1, 0, 2, 0, 1, 1);
        addRow(OpIssue,  1, 2, 1, 3, 0, 0, 1);
        // test 2 results out of order, commit in tag order
        addRow(OpIssue,  2, 3, 2, 1, 0, 0, 0);
        addRow(OpResult, 2, 0, 3, 0, 2, 0, 1);
        addRow(OpResult, 2, 0, 2, 3, 1, 0, 0);
        addRow(OpResult, 2, 0, 1, 2, 0, 0, 0);
        addRow(OpIdle,   2, 0, 1, 2, 0, 1, 0);
        addRow(OpIdle,   2, 0, 2, 3, 0, 1, 0);
        addRow(OpIdle,   2, 0, 3, 1, 0, 1, 1);
        addRow(OpIdle,   2, 0, 1, 2, 0, 1, 1);
        // test 3 bypass in the commit cycle
        addRow(OpIssue,  3, 4, 4, 0, 0, 1, 1);
        addRow(OpResult, 3, 0, 4, 0, 3, 0, 1);
        addRow(OpWait,   3, 0, 4, 0, 0, 1, 1);
        addRow(OpIdle,   3, 0, 4, 0, 0, 1, 1);
        // test 4 older writer of a renamed register
        addRow(OpIssue,  4, 5, 5, 0, 0, 1, 1);
        addRow(OpIssue,  4, 5, 5, 0, 0, 0, 1);
        addRow(OpResult, 4, 0, 5, 0, 4, 0, 1);
        addRow(OpIdle,   4, 0, 5, 0, 0, 0, 1);
        addRow(OpIdle,   4, 0, 5, 0, 0, 0, 1);
        addRow(OpResult, 4, 0, 5, 0, 5, 0, 1);
        addRow(OpIdle,   4, 0, 5, 0, 0, 1, 1);
        addRow(OpIdle,   4, 0, 5, 0, 0, 1, 1);
        // test 5 sixteen in flight, tags 6 to 21
        for (int i = 0; i < 16; i++) begin
            addRow(OpIssue, 5, 6 + (i % 4), 0, 0, 0, 1, 1);
        end
        addRow(OpIssue,  5, 7, 0, 0, 0, 1, 1);
        addRow(OpIssue,  5, 7, 0, 0, 0, 1, 1);
        addRow(OpResult, 5, 0, 0, 0, 6, 1, 1);
        addRow(OpIssue,  5, 7, 0, 0, 0, 1, 1);
        addRow(OpIssue,  5, 7, 0, 0, 0, 1, 1);
        for (int t = 7; t <= 22; t++) begin
            addRow(OpResult, 5, 0, 0, 0, t, 1, 1);
        end
        addRow(OpIdle,   5, 0, 0, 0, 0, 1, 1);
        addRow(OpIdle,   5, 0, 0, 0, 0, 1, 1);
        // test 6 flush younger than tag 24
        addRow(OpIssue,  6, 10, 0, 0, 0, 1, 1);
        addRow(OpIssue,  6, 0, 0, 0, 0, 1, 1);
        addRow(OpIssue,  6, 6, 10, 0, 0, 0, 1);
        addRow(OpIssue,  6, 7, 6, 0, 0, 0, 1);
        addRow(OpBranch, 6, 0, 6, 7, 24, 0, 0);
        addRow(OpIdle,   6, 0, 6, 7, 0, 1, 1);
        addRow(OpResult, 6, 0, 6, 7, 25, 1, 1);
        addRow(OpResult, 6, 0, 6, 10, 26, 1, 0);
        addRow(OpResult, 6, 0, 6, 7, 24, 1, 1);
        addRow(OpResult, 6, 0, 10, 0, 23, 0, 1);
        addRow(OpIdle,   6, 0, 10, 6, 0, 1, 1);
        addRow(OpIdle,   6, 0, 10, 7, 0, 1, 1);
        addRow(OpIssue,  6, 8, 8, 0, 0, 1, 1);
        addRow(OpResult, 6, 0, 8, 0, 25, 0, 1);
        addRow(OpWait,   6, 0, 8, 0, 0, 1, 1);
        addRow(OpIdle,   6, 0, 8, 7, 0, 1, 1);
    endtask

    initial begin
        rst         = 1'b1;
        issueValid  = 1'b0;
        issueDest   = '0;
        issueSrc[0] = '0;
        issueSrc[1] = '0;
        exValid     = 1'b0;
        exTag       = '0;
        exResult    = '0;
        branchTaken = 1'b0;
        branchTag   = '0;
        lfsrState   = 16'd99;
        errCount    = 0;
        checkCount  = 0;
        testErr     = 0;
        testCnt     = 0;
        curTest     = 0;
        mHead       = '0;
        mNext       = '0;
        for (int g = 0; g < 32; g++) begin
            mValue[g] = '0;
            mPend[g]  = 1'b0;
            mTag[g]   = '0;
        end
        for (int t = 0; t < 64; t++) begin
            qValid[t] = 1'b0;
            qDone[t]  = 1'b0;
            qDest[t]  = '0;
            qRes[t]   = '0;
        end
        buildTable();

        repeat (3) @(posedge clk);
        #2 rst = 1'b0;

        foreach (rows[i]) begin
            if (rows[i].test != curTest) begin
                if (curTest != 0) begin
                    reportTest();
                end
                curTest = rows[i].test;
                testErr = 0;
            end
            applyRow(rows[i]);
        end
        reportTest();

        $display("tests %0d, checks %0d, errors %0d", testCnt, checkCount, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: regRename.f
+incdir+include
verilog/renamePkg.sv
verilog/registerAliasTable.sv
verilog/reorderBuffer.sv
verilog/operandSelect.sv
verilog/renameStage.sv
verification/renameStageTb.sv

// File: Makefile
# Verilator build and run for the register rename block

TOOL     := verilator
TOP      := renameStageTb
FILELIST := regRename.f
FLAGS    := --binary --timing --assert -j 0
BUILDDIR := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

# the log decides the result, so a missing pass line fails the target
run: compile
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
